// File: source/video_pkg.sv
`default_nettype none

package video_pkg;

    // one pixel from each layer generator, sampled together
    typedef struct packed {
        logic [3:0] char_pxl;   // character colour code
        logic [3:0] scr1_pxl;   // scroll 1 colour code
        logic [5:0] scr2_pxl;   // scroll 2, bits 5:4 pick the palette bank
        logic [7:0] obj_pxl;    // object, bit 7 is the priority flag
    } layer_pixels_t;

    // low two bits of a priority PROM entry
    // also lands in palette address bits 7:6
    typedef enum logic [1:0] {
        LAYER_SCR2 = 2'd0,
        LAYER_SCR1 = 2'd1,
        LAYER_OBJ  = 2'd2,
        LAYER_CHAR = 2'd3
    } layer_e;

    // palette PROM address
    // {layer, bank, colour code}
    typedef logic [7:0] pal_addr_t;

    // 12-bit colour, red in the top nibble
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // layer enables for debug
    // bit 0 char, 1 scr1, 2 scr2, 3 obj
    typedef logic [3:0] gfx_en_t;

endpackage

`default_nettype wire

// File: source/prom_pkg.sv
`default_nettype none

package prom_pkg;

    // bus address bits 9:8
    // red/green/blue follow the rgb write strobe order
    typedef enum logic [1:0] {
        PROM_RED   = 2'd0,
        PROM_GREEN = 2'd1,
        PROM_BLUE  = 2'd2,
        PROM_PRIO  = 2'd3
    } prom_sel_e;

    // Wishbone classic request from the master
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [9:0] adr;    // 9:8 PROM select, 7:0 PROM address
        logic [7:0] dat;    // write data
    } wb_req_t;

    // PROM write port shared by all PROMs
    // at most one strobe is high per clock
    typedef struct packed {
        logic [7:0] addr;   // priority PROM only uses 4:0
        logic [7:0] din;    // palette PROMs take the low nibble
        logic [2:0] we_rgb; // 0 red, 1 green, 2 blue
        logic       we_prio;
    } prom_wr_t;

endpackage

`default_nettype wire

// File: source/prom_ram.sv
`timescale 1ns/1ps
`default_nettype none

module prom_ram #(
    parameter int AW = 8,
    parameter int DW = 4
) (
    input  logic          clk,
    input  logic          cen,
    input  logic [DW-1:0] data,
    input  logic [AW-1:0] rd_addr,
    input  logic [AW-1:0] wr_addr,
    input  logic          we,
    output logic [DW-1:0] q
);

    logic [DW-1:0] mem [2**AW]; // contents survive reset

    // write side ignores cen, loading runs at full clock rate
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];  // registered read
        end
    end

endmodule

`default_nettype wire

// File: source/prom_loader.sv
`timescale 1ns/1ps
`default_nettype none

module prom_loader (
    input  logic               clk,
    input  logic               reset,
    input  prom_pkg::wb_req_t  wb_req,
    output logic               ack,
    output logic [7:0]         dat_o,
    output prom_pkg::prom_wr_t prom_wr
);

    import prom_pkg::*;

    typedef enum logic {
        LOAD_IDLE,
        LOAD_ACK
    } load_state_e;

    load_state_e state;
    load_state_e state_nxt;
    logic        req;       // qualified request
    logic        wr_cycle;  // ack of a write
    prom_sel_e   sel;

    assign req = wb_req.cyc && wb_req.stb;
    assign sel = prom_sel_e'(wb_req.adr[9:8]);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LOAD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            LOAD_IDLE: if (req) state_nxt = LOAD_ACK;  // sample, ack next clock
            LOAD_ACK:  state_nxt = LOAD_IDLE;          // single cycle ack
            default:   state_nxt = LOAD_IDLE;
        endcase
    end

    // dropped if the master aborts mid cycle
    assign ack      = (state == LOAD_ACK) && req;
    assign wr_cycle = ack && wb_req.we;

    // strobe lines up with ack, master still holds adr and dat
    always_comb begin
        prom_wr      = '0;
        prom_wr.addr = wb_req.adr[7:0];
        prom_wr.din  = wb_req.dat;
        if (wr_cycle) begin
            case (sel)
                PROM_RED, PROM_GREEN, PROM_BLUE: prom_wr.we_rgb[sel] = 1'b1;
                PROM_PRIO: prom_wr.we_prio = (wb_req.adr[7:5] == 3'd0); // 32 entries only
            endcase
        end
    end

    assign dat_o = 8'h00;   // PROMs are write only from the bus

endmodule

`default_nettype wire

// File: source/layer_prio.sv
`timescale 1ns/1ps
`default_nettype none

module layer_prio (
    input  logic                     clk,
    input  video_pkg::layer_pixels_t pixels,
    input  video_pkg::gfx_en_t       gfx_en,
    input  prom_pkg::prom_wr_t       prom_wr,
    output video_pkg::pal_addr_t     pal_addr
);

    import video_pkg::*;

    logic       char_vis;   // high means not blank
    logic       scr1_vis;
    logic       obj_vis;
    logic [4:0] prio_addr;
    logic [7:0] prio_q;     // raw priority entry
    layer_e     sel;

    // all ones is the transparent code
    assign char_vis = gfx_en[0] && !(&pixels.char_pxl);
    assign scr1_vis = gfx_en[1] && !(&pixels.scr1_pxl);
    assign obj_vis  = gfx_en[3] && !(&pixels.obj_pxl);  // full 8 bits checked

    assign prio_addr = {
        1'b0,
        char_vis,
        pixels.obj_pxl[7],  // object priority flag
        obj_vis,
        scr1_vis
    };

    // read every clock, selection settles one clock after the pixels
    prom_ram #(
        .AW (5),
        .DW (8)
    ) i_prio_prom (
        .clk     (clk),
        .cen     (1'b1),
        .data    (prom_wr.din),
        .rd_addr (prio_addr),
        .wr_addr (prom_wr.addr[4:0]),
        .we      (prom_wr.we_prio),   // range already checked by the loader
        .q       (prio_q)
    );

    assign sel = layer_e'(prio_q[1:0]);

    // palette address, {layer, bank, code}
    always_comb begin
        pal_addr[7:6] = sel;
        pal_addr[5:4] = 2'b00;      // char and scr1 have a single bank
        case (sel)
            LAYER_CHAR: begin
                pal_addr[3:0] = pixels.char_pxl;
            end
            LAYER_OBJ: begin
                pal_addr[5:4] = pixels.obj_pxl[5:4];
                pal_addr[3:0] = pixels.obj_pxl[3:0];
            end
            LAYER_SCR1: begin
                pal_addr[3:0] = pixels.scr1_pxl;
            end
            default: begin          // LAYER_SCR2
                pal_addr[5:4] = pixels.scr2_pxl[5:4];
                pal_addr[3:0] = pixels.scr2_pxl[3:0];
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/blank_delay.sv
`timescale 1ns/1ps
`default_nettype none

module blank_delay #(
    parameter int BLANK_DLY = 3     // at least 2, palette takes the first beat
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            pxl_cen,
    input  logic            LHBL,
    input  logic            LVBL,
    input  video_pkg::rgb_t rgb_in,
    output logic            LHBL_dly,
    output logic            LVBL_dly,
    output video_pkg::rgb_t rgb
);

    import video_pkg::*;

    logic [BLANK_DLY-1:0] lhbl_sr;
    logic [BLANK_DLY-1:0] lvbl_sr;
    rgb_t                 rgb_sr [BLANK_DLY-1];  // one stage short

    always_ff @(posedge clk) begin
        if (reset) begin
            lhbl_sr <= '0;      // comes out of reset blanked
            lvbl_sr <= '0;
            for (int i = 0; i < BLANK_DLY-1; i++) begin
                rgb_sr[i] <= '0;
            end
        end else if (pxl_cen) begin
            lhbl_sr   <= {lhbl_sr[BLANK_DLY-2:0], LHBL};
            lvbl_sr   <= {lvbl_sr[BLANK_DLY-2:0], LVBL};
            rgb_sr[0] <= rgb_in;
            for (int i = 1; i < BLANK_DLY-1; i++) begin
                rgb_sr[i] <= rgb_sr[i-1];
            end
        end
    end

    assign LHBL_dly = lhbl_sr[BLANK_DLY-1];
    assign LVBL_dly = lvbl_sr[BLANK_DLY-1];
    // black outside the active area
    assign rgb = (LHBL_dly && LVBL_dly) ? rgb_sr[BLANK_DLY-2] : '0;

endmodule

`default_nettype wire

// File: source/colmix_top.sv
`timescale 1ns/1ps
`default_nettype none

module colmix_top #(
    parameter int BLANK_DLY = 3
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     pxl_cen,
    // PROM loading bus
    input  prom_pkg::wb_req_t        wb_req,
    output logic                     ack,
    output logic [7:0]               dat_o,
    // layer pixels
    input  video_pkg::layer_pixels_t pixels,
    input  video_pkg::gfx_en_t       gfx_en,
    input  logic                     LHBL,
    input  logic                     LVBL,
    output logic                     LHBL_dly,
    output logic                     LVBL_dly,
    output video_pkg::rgb_t          rgb
);

    import video_pkg::*;
    import prom_pkg::*;

    prom_wr_t  prom_wr;
    pal_addr_t pal_addr;
    rgb_t      pal_rgb;     // palette output, one beat after pal_addr

    prom_loader i_prom_loader (
        .clk     (clk),
        .reset   (reset),
        .wb_req  (wb_req),
        .ack     (ack),
        .dat_o   (dat_o),
        .prom_wr (prom_wr)
    );

    layer_prio i_layer_prio (
        .clk      (clk),
        .pixels   (pixels),
        .gfx_en   (gfx_en),
        .prom_wr  (prom_wr),
        .pal_addr (pal_addr)
    );

    // one palette PROM per colour, index follows prom_sel_e
    for (genvar c = 0; c < 3; c++) begin : g_pal
        logic [3:0] pal_q;

        prom_ram #(
            .AW (8),
            .DW (4)
        ) i_pal_prom (
            .clk     (clk),
            .cen     (pxl_cen),
            .data    (prom_wr.din[3:0]),
            .rd_addr (pal_addr),
            .wr_addr (prom_wr.addr),
            .we      (prom_wr.we_rgb[c]),
            .q       (pal_q)
        );

        if (c == PROM_RED) begin : g_red
            assign pal_rgb.red = pal_q;
        end else if (c == PROM_GREEN) begin : g_green
            assign pal_rgb.green = pal_q;
        end else begin : g_blue
            assign pal_rgb.blue = pal_q;
        end
    end

    blank_delay #(
        .BLANK_DLY (BLANK_DLY)
    ) i_blank_delay (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .LHBL     (LHBL),
        .LVBL     (LVBL),
        .rgb_in   (pal_rgb),
        .LHBL_dly (LHBL_dly),
        .LVBL_dly (LVBL_dly),
        .rgb      (rgb)
    );

endmodule

`default_nettype wire

// File: tests/colmix_properties.sv
`timescale 1ns/1ps
`default_nettype none

module colmix_properties #(
    parameter int BLANK_DLY = 3
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               pxl_cen,
    input  prom_pkg::wb_req_t  wb_req,
    input  logic               ack,
    input  prom_pkg::prom_wr_t prom_wr,
    input  logic               LHBL_dly,
    input  logic               LVBL_dly
);

    int beats;  // pixel beats since reset, saturating

    always_ff @(posedge clk) begin
        if (reset) begin
            beats <= 0;
        end else if (pxl_cen && beats < BLANK_DLY) begin
            beats <= beats + 1;
        end
    end

    ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        ack |-> (wb_req.cyc && wb_req.stb))
        else $error("ack outside a bus cycle");

    ack_single: assert property (@(posedge clk) disable iff (reset)
        ack |=> !ack)
        else $error("ack lasted two clocks");

    one_strobe: assert property (@(posedge clk) disable iff (reset)
        $onehot0({prom_wr.we_rgb, prom_wr.we_prio}))
        else $error("more than one PROM write strobe");

    // shift registers still hold reset zeros
    blank_after_reset: assert property (@(posedge clk) disable iff (reset)
        (beats < BLANK_DLY) |-> (!LHBL_dly && !LVBL_dly))
        else $error("blanking released too early after reset");

endmodule

bind colmix_top colmix_properties #(
    .BLANK_DLY (BLANK_DLY)
) i_colmix_properties (
    .clk      (clk),
    .reset    (reset),
    .pxl_cen  (pxl_cen),
    .wb_req   (wb_req),
    .ack      (ack),
    .prom_wr  (prom_wr),
    .LHBL_dly (LHBL_dly),
    .LVBL_dly (LVBL_dly)
);

`default_nettype wire

// File: tests/colmix_tb.sv
`timescale 1ns/1ps
`default_nettype none

module colmix_tb;

    import video_pkg::*;
    import prom_pkg::*;

    localparam int BLANK_DLY = 3;
    localparam int N_PIX     = 300;     // beats per video test
    // three clocks per bus cycle, two per pixel beat
    localparam int RUN_CYCLES = 50 + (8 + 32 + 768 + 32 + 16) * 3 + 4 * (2 * N_PIX + 20);
    localparam int MAX_CYCLES = RUN_CYCLES * 12 / 10;

    typedef struct packed {
        rgb_t rgb;
        logic lhbl;
        logic lvbl;
    } expect_t;

    logic          clk = 1'b0;
    logic          reset;
    logic          cen_cnt = 1'b0;
    logic          pxl_cen;
    wb_req_t       wb_req;
    logic          ack;
    logic [7:0]    dat_o;
    layer_pixels_t pixels;
    gfx_en_t       gfx_en;
    logic          LHBL;
    logic          LVBL;
    logic          LHBL_dly;
    logic          LVBL_dly;
    rgb_t          rgb;

    integer     seed = 32'h811a_856f;
    logic [3:0] pal_ref [3][256];   // mirror of what the bus wrote
    logic [7:0] prio_ref [32];
    expect_t    exp_q [$];          // one entry per beat
    logic       checking = 1'b0;
    int         tests = 0;
    int         checks = 0;
    int         errors = 0;
    int         cycles = 0;

    colmix_top #(.BLANK_DLY(BLANK_DLY)) i_colmix_top (.*);

    always #4 clk = ~clk;
    always @(negedge clk) cen_cnt <= cen_cnt + 1'b1;   // beat every second clock
    assign pxl_cen = cen_cnt;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d clocks", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    task automatic check_rgb(input rgb_t got, input rgb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %0t ns: rgb %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_blank(input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %0t ns: LHBL_dly,LVBL_dly %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_ack(input logic got, input logic exp, input logic [7:0] dat,
                             input string what);
        checks++;
        if (got !== exp || dat !== 8'h00) begin
            errors++;
            $display("** Error: %0t ns: %s, ack %b dat_o %h, expected ack %b dat_o 00",
                     $time, what, got, dat, exp);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, errors - mark);
    endtask

    // one classic cycle, request held until the ack edge has passed
    task automatic bus_cycle(input logic we, input logic [9:0] adr, input logic [7:0] dat);
        int lat;
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        @(negedge clk);
        check_ack(ack, 1'b1, dat_o, "ack one clock after request");
        lat = 1;
        while (!ack && lat < 8) begin
            @(negedge clk);
            lat++;
        end
        if (!ack) begin
            errors++;
            $display("bus cycle to address %h was never acknowledged", adr);
        end
        @(negedge clk);
        check_ack(ack, 1'b0, dat_o, "ack held into a second clock");
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic prom_write(input prom_sel_e sel, input logic [7:0] addr,
                              input logic [7:0] dat);
        bus_cycle(1'b1, {sel, addr}, dat);
        if (sel == PROM_PRIO) begin
            if (addr[7:5] == 3'd0) prio_ref[addr[4:0]] = dat;  // only 32 entries decode
        end else begin
            pal_ref[sel][addr] = dat[3:0];
        end
    endtask

    // returns on the falling edge right after a pixel beat
    task automatic wait_beat();
        do begin
            @(posedge clk);
        end while (!pxl_cen);
        @(negedge clk);
    endtask

    task automatic run_pixels(input int n, input logic rand_gfx, input logic rand_blank);
        logic [31:0] r;
        logic [31:0] c;
        for (int i = 0; i < n; i++) begin
            wait_beat();
            r = rand32();
            c = rand32();
            pixels = r[21:0];
            if (r[31:29] == 3'd0) pixels.obj_pxl = 8'hff;   // transparent object
            gfx_en = rand_gfx ? c[3:0] : 4'hf;
            LHBL   = rand_blank ? (c[5:4] != 2'b00) : 1'b1;
            LVBL   = rand_blank ? (c[7:6] != 2'b00) : 1'b1;
            checking = 1'b1;
        end
        wait_beat();
        checking = 1'b0;
    endtask

    // expected colour from the mirrored PROMs
    function automatic rgb_t expected_rgb(input layer_pixels_t px, input gfx_en_t en,
                                          input logic hb, input logic vb);
        logic [4:0] pa;
        layer_e     lay;
        logic [1:0] bank;
        logic [3:0] code;
        logic [7:0] idx;
        rgb_t       c;
        pa = {1'b0, en[0] && px.char_pxl != 4'hf, px.obj_pxl[7],
              en[3] && px.obj_pxl != 8'hff, en[1] && px.scr1_pxl != 4'hf};
        lay  = layer_e'(prio_ref[pa][1:0]);
        bank = 2'b00;
        code = px.char_pxl;
        if (lay == LAYER_SCR2) begin
            {bank, code} = px.scr2_pxl;
        end else if (lay == LAYER_OBJ) begin
            {bank, code} = px.obj_pxl[5:0];
        end else if (lay == LAYER_SCR1) begin
            code = px.scr1_pxl;
        end
        idx = {lay, bank, code};
        c.red   = pal_ref[PROM_RED][idx];
        c.green = pal_ref[PROM_GREEN][idx];
        c.blue  = pal_ref[PROM_BLUE][idx];
        return (hb && vb) ? c : '0;   // black while blanked
    endfunction

    // outputs at beat k belong to the inputs of beat k-BLANK_DLY
    always @(posedge clk) begin : compare
        expect_t e;
        if (reset || !checking) begin
            exp_q.delete();
        end else if (pxl_cen) begin
            e.rgb  = expected_rgb(pixels, gfx_en, LHBL, LVBL);
            e.lhbl = LHBL;
            e.lvbl = LVBL;
            exp_q.push_back(e);
            if (exp_q.size() > BLANK_DLY) begin
                e = exp_q.pop_front();
                check_blank({LHBL_dly, LVBL_dly}, {e.lhbl, e.lvbl});
                check_rgb(rgb, e.rgb);
            end
        end
    end

    initial begin : main
        int          mark;
        logic [31:0] r;
        reset  = 1'b1;
        wb_req = '0;
        pixels = '0;
        gfx_en = 4'hf;
        LHBL   = 1'b1;  // active video at the inputs, outputs must stay blanked
        LVBL   = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        mark = errors;
        @(negedge clk);
        check_blank({LHBL_dly, LVBL_dly}, 2'b00);
        check_rgb(rgb, '0);
        check_ack(ack, 1'b0, dat_o, "ack after reset");
        report_test("idle after reset", mark);

        mark = errors;
        for (int i = 0; i < 4; i++) begin
            r = rand32();
            prom_write(PROM_RED, r[7:0], r[15:8]);
            bus_cycle(1'b0, {PROM_PRIO, r[23:16]}, r[31:24]);   // read
        end
        report_test("bus handshake", mark);

        mark = errors;
        for (int i = 0; i < 32; i++) begin
            r = rand32();
            prom_write(PROM_PRIO, 8'(i), {r[7:2], LAYER_CHAR});
        end
        for (int s = 0; s < 3; s++) begin
            for (int a = 0; a < 256; a++) begin
                r = rand32();
                prom_write(prom_sel_e'(s), 8'(a), r[7:0]);
            end
        end
        run_pixels(N_PIX, 1'b0, 1'b0);
        report_test("char layer, random palette", mark);

        mark = errors;
        for (int i = 0; i < 32; i++) begin
            r = rand32();
            prom_write(PROM_PRIO, 8'(i), r[7:0]);
        end
        run_pixels(N_PIX, 1'b0, 1'b0);
        report_test("random priority table", mark);

        mark = errors;
        for (int i = 0; i < 16; i++) begin
            r = rand32();
            // address 32 and up, past the table
            prom_write(PROM_PRIO, {(r[7:5] == 3'd0) ? 3'd7 : r[7:5], r[4:0]}, r[15:8]);
        end
        run_pixels(N_PIX, 1'b1, 1'b0);
        report_test("layer enables, stray priority writes", mark);

        mark = errors;
        run_pixels(N_PIX, 1'b0, 1'b1);
        report_test("blanking delay", mark);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
source/video_pkg.sv
source/prom_pkg.sv
source/prom_ram.sv
source/prom_loader.sv
source/layer_prio.sv
source/blank_delay.sv
source/colmix_top.sv
tests/colmix_properties.sv
tests/colmix_tb.sv

// File: Makefile
# Verilator build and run of the colour mixer testbench

OBJ := obj_dir
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module colmix_tb -Mdir $(OBJ)

run: compile
	./$(OBJ)/Vcolmix_tb | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ) $(LOG)
